/* src/rs_pkg.sv */
`default_nettype none

package rs_pkg;

    localparam int PREG_W = 6;  // physical register tag
    localparam int ROB_W  = 6;
    localparam int OP_W   = 4;
    localparam int SEL_W  = 2;

    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [ROB_W-1:0]  rob_idx_t;
    typedef logic [OP_W-1:0]   op_t;
    typedef logic [SEL_W-1:0]  rs_sel_t;

    // code 3 selects no station
    localparam rs_sel_t RS_SEL_ALU = 2'd0;
    localparam rs_sel_t RS_SEL_MUL = 2'd1;
    localparam rs_sel_t RS_SEL_DIV = 2'd2;

    localparam int ALU_ENTRIES = 4;
    localparam int MUL_ENTRIES = 2;
    localparam int DIV_ENTRIES = 2;

    // true when tag is broadcast on any valid result port
    function automatic logic result_hit(
        input preg_t tag,
        input logic  alu_valid,
        input preg_t alu_tag,
        input logic  mul_valid,
        input preg_t mul_tag,
        input logic  div_valid,
        input preg_t div_tag
    );
        return (alu_valid && (alu_tag == tag))
            || (mul_valid && (mul_tag == tag))
            || (div_valid && (div_tag == tag));
    endfunction

endpackage

`default_nettype wire

/* src/rs_pick.sv */
`timescale 1ns/100ps
`default_nettype none

// lowest set bit wins
module rs_pick #(
    parameter int width = 4
) (
    input  wire  [width-1:0]         req,
    output logic                     found,
    output logic [$clog2(width)-1:0] index
);

    assign found = |req;

    always_comb
    begin
        index = '0;
        // walk down so the lowest request is the last one written
        for (int i = width - 1; i >= 0; i--)
        begin
            if (req[i])
            begin
                index = i[$clog2(width)-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* src/rs_station.sv */
`timescale 1ns/100ps
`default_nettype none

module rs_station #(
    parameter int num_entries = 4
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   insert,        // already gated by full
    input  wire rs_pkg::preg_t    ps1,
    input  wire rs_pkg::preg_t    ps2,
    input  wire rs_pkg::preg_t    pd,
    input  wire                   src1_ready,
    input  wire                   src2_ready,
    input  wire rs_pkg::rob_idx_t rob_entry,
    input  wire rs_pkg::op_t      op,
    input  wire                   alu_result_valid,
    input  wire                   mul_result_valid,
    input  wire                   div_result_valid,
    input  wire rs_pkg::preg_t    alu_result_tag,
    input  wire rs_pkg::preg_t    mul_result_tag,
    input  wire rs_pkg::preg_t    div_result_tag,
    input  wire                   fu_busy,
    output logic                  fu_ready,
    output rs_pkg::preg_t         issue_ps1,
    output rs_pkg::preg_t         issue_ps2,
    output rs_pkg::preg_t         issue_pd,
    output rs_pkg::rob_idx_t      issue_rob_entry,
    output rs_pkg::op_t           issue_op,
    output logic                  full
);

    // per-entry control bits
    logic [num_entries-1:0] busy;
    logic [num_entries-1:0] rdy1;
    logic [num_entries-1:0] rdy2;

    // per-entry payload
    rs_pkg::preg_t    ent_ps1 [num_entries];
    rs_pkg::preg_t    ent_ps2 [num_entries];
    rs_pkg::preg_t    ent_pd  [num_entries];
    rs_pkg::rob_idx_t ent_rob [num_entries];
    rs_pkg::op_t      ent_op  [num_entries];

    logic [num_entries-1:0] hit1;
    logic [num_entries-1:0] hit2;
    logic [num_entries-1:0] ready_mask;

    logic                           free_found;
    logic                           ready_found;
    logic [$clog2(num_entries)-1:0] free_idx;
    logic [$clog2(num_entries)-1:0] issue_idx;

    // live tag compare for every stored source
    always_comb
    begin
        for (int i = 0; i < num_entries; i++)
        begin
            hit1[i] = rs_pkg::result_hit(ent_ps1[i],
                                         alu_result_valid, alu_result_tag,
                                         mul_result_valid, mul_result_tag,
                                         div_result_valid, div_result_tag);
            hit2[i] = rs_pkg::result_hit(ent_ps2[i],
                                         alu_result_valid, alu_result_tag,
                                         mul_result_valid, mul_result_tag,
                                         div_result_valid, div_result_tag);
        end
    end

    assign ready_mask = busy & rdy1 & rdy2;

    rs_pick #(.width(num_entries)) free_pick_i (
        .req   (~busy),
        .found (free_found),
        .index (free_idx)
    );

    rs_pick #(.width(num_entries)) ready_pick_i (
        .req   (ready_mask),
        .found (ready_found),
        .index (issue_idx)
    );

    assign full     = ~free_found;
    assign fu_ready = ready_found & ~fu_busy;  // unit takes it this cycle

    always_comb
    begin
        issue_ps1       = '0;
        issue_ps2       = '0;
        issue_pd        = '0;
        issue_rob_entry = '0;
        issue_op        = '0;
        if (fu_ready)
        begin
            issue_ps1       = ent_ps1[issue_idx];
            issue_ps2       = ent_ps2[issue_idx];
            issue_pd        = ent_pd[issue_idx];
            issue_rob_entry = ent_rob[issue_idx];
            issue_op        = ent_op[issue_idx];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= '0;
            rdy1 <= '0;
            rdy2 <= '0;
        end
        else
        begin
            rdy1 <= rdy1 | hit1;  // wakeup of waiting entries
            rdy2 <= rdy2 | hit2;
            if (fu_ready)
            begin
                busy[issue_idx] <= 1'b0;
            end
            // free slot never equals the issuing slot
            if (insert)
            begin
                busy[free_idx] <= 1'b1;
                rdy1[free_idx] <= src1_ready;
                rdy2[free_idx] <= src2_ready;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (insert)
        begin
            ent_ps1[free_idx] <= ps1;
            ent_ps2[free_idx] <= ps2;
            ent_pd[free_idx]  <= pd;
            ent_rob[free_idx] <= rob_entry;
            ent_op[free_idx]  <= op;
        end
    end

endmodule

`default_nettype wire

/* src/rs_dispatch_route.sv */
`timescale 1ns/100ps
`default_nettype none

module rs_dispatch_route (
    input  wire                  dispatch_valid,
    input  wire rs_pkg::rs_sel_t rs_select,
    input  wire rs_pkg::preg_t   ps1,
    input  wire rs_pkg::preg_t   ps2,
    input  wire                  ps1_ready,
    input  wire                  ps2_ready,
    input  wire                  alu_result_valid,
    input  wire                  mul_result_valid,
    input  wire                  div_result_valid,
    input  wire rs_pkg::preg_t   alu_result_tag,
    input  wire rs_pkg::preg_t   mul_result_tag,
    input  wire rs_pkg::preg_t   div_result_tag,
    input  wire                  alu_full,
    input  wire                  mul_full,
    input  wire                  div_full,
    output logic                 alu_insert,
    output logic                 mul_insert,
    output logic                 div_insert,
    output logic                 src1_ready,
    output logic                 src2_ready
);

    logic src1_hit;
    logic src2_hit;

    // a full station or select code 3 drops the instruction
    always_comb
    begin
        alu_insert = 1'b0;
        mul_insert = 1'b0;
        div_insert = 1'b0;
        if (dispatch_valid)
        begin
            case (rs_select)
                rs_pkg::RS_SEL_ALU: alu_insert = ~alu_full;
                rs_pkg::RS_SEL_MUL: mul_insert = ~mul_full;
                rs_pkg::RS_SEL_DIV: div_insert = ~div_full;
                default: ;  // unused code
            endcase
        end
    end

    // same-cycle broadcast counts as ready at dispatch
    assign src1_hit = rs_pkg::result_hit(ps1,
                                         alu_result_valid, alu_result_tag,
                                         mul_result_valid, mul_result_tag,
                                         div_result_valid, div_result_tag);
    assign src2_hit = rs_pkg::result_hit(ps2,
                                         alu_result_valid, alu_result_tag,
                                         mul_result_valid, mul_result_tag,
                                         div_result_valid, div_result_tag);

    assign src1_ready = ps1_ready | src1_hit;
    assign src2_ready = ps2_ready | src2_hit;

endmodule

`default_nettype wire

/* src/rs_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rs_top (
    input  wire                   clk,
    input  wire                   rst,

    // dispatch
    input  wire                   dispatch_valid,
    input  wire rs_pkg::rs_sel_t  rs_select,
    input  wire rs_pkg::preg_t    ps1,
    input  wire rs_pkg::preg_t    ps2,
    input  wire                   ps1_ready,
    input  wire                   ps2_ready,
    input  wire rs_pkg::preg_t    pd,
    input  wire rs_pkg::rob_idx_t rob_entry,
    input  wire rs_pkg::op_t      op,
    output logic                  alu_full,
    output logic                  mul_full,
    output logic                  div_full,

    // result bus
    input  wire                   alu_result_valid,
    input  wire rs_pkg::preg_t    alu_result_tag,
    input  wire                   mul_result_valid,
    input  wire rs_pkg::preg_t    mul_result_tag,
    input  wire                   div_result_valid,
    input  wire rs_pkg::preg_t    div_result_tag,

    // functional units
    input  wire                   alu_fu_busy,
    output logic                  alu_fu_ready,
    output rs_pkg::preg_t         alu_ps1,
    output rs_pkg::preg_t         alu_ps2,
    output rs_pkg::preg_t         alu_pd,
    output rs_pkg::rob_idx_t      alu_rob_entry,
    output rs_pkg::op_t           alu_op,
    input  wire                   mul_fu_busy,
    output logic                  mul_fu_ready,
    output rs_pkg::preg_t         mul_ps1,
    output rs_pkg::preg_t         mul_ps2,
    output rs_pkg::preg_t         mul_pd,
    output rs_pkg::rob_idx_t      mul_rob_entry,
    output rs_pkg::op_t           mul_op,
    input  wire                   div_fu_busy,
    output logic                  div_fu_ready,
    output rs_pkg::preg_t         div_ps1,
    output rs_pkg::preg_t         div_ps2,
    output rs_pkg::preg_t         div_pd,
    output rs_pkg::rob_idx_t      div_rob_entry,
    output rs_pkg::op_t           div_op
);

    logic alu_insert;
    logic mul_insert;
    logic div_insert;
    logic src1_ready;  // shared by all three stations
    logic src2_ready;

    rs_dispatch_route route_i (
        .dispatch_valid   (dispatch_valid),
        .rs_select        (rs_select),
        .ps1              (ps1),
        .ps2              (ps2),
        .ps1_ready        (ps1_ready),
        .ps2_ready        (ps2_ready),
        .alu_result_valid (alu_result_valid),
        .mul_result_valid (mul_result_valid),
        .div_result_valid (div_result_valid),
        .alu_result_tag   (alu_result_tag),
        .mul_result_tag   (mul_result_tag),
        .div_result_tag   (div_result_tag),
        .alu_full         (alu_full),
        .mul_full         (mul_full),
        .div_full         (div_full),
        .alu_insert       (alu_insert),
        .mul_insert       (mul_insert),
        .div_insert       (div_insert),
        .src1_ready       (src1_ready),
        .src2_ready       (src2_ready)
    );

    rs_station #(.num_entries(rs_pkg::ALU_ENTRIES)) alu_rs_i (
        .clk (clk), .rst (rst), .insert (alu_insert),
        .ps1 (ps1), .ps2 (ps2), .pd (pd),
        .src1_ready (src1_ready), .src2_ready (src2_ready),
        .rob_entry (rob_entry), .op (op),
        .alu_result_valid (alu_result_valid), .mul_result_valid (mul_result_valid),
        .div_result_valid (div_result_valid), .alu_result_tag (alu_result_tag),
        .mul_result_tag (mul_result_tag), .div_result_tag (div_result_tag),
        .fu_busy (alu_fu_busy), .fu_ready (alu_fu_ready),
        .issue_ps1 (alu_ps1), .issue_ps2 (alu_ps2), .issue_pd (alu_pd),
        .issue_rob_entry (alu_rob_entry), .issue_op (alu_op), .full (alu_full)
    );

    rs_station #(.num_entries(rs_pkg::MUL_ENTRIES)) mul_rs_i (
        .clk (clk), .rst (rst), .insert (mul_insert),
        .ps1 (ps1), .ps2 (ps2), .pd (pd),
        .src1_ready (src1_ready), .src2_ready (src2_ready),
        .rob_entry (rob_entry), .op (op),
        .alu_result_valid (alu_result_valid), .mul_result_valid (mul_result_valid),
        .div_result_valid (div_result_valid), .alu_result_tag (alu_result_tag),
        .mul_result_tag (mul_result_tag), .div_result_tag (div_result_tag),
        .fu_busy (mul_fu_busy), .fu_ready (mul_fu_ready),
        .issue_ps1 (mul_ps1), .issue_ps2 (mul_ps2), .issue_pd (mul_pd),
        .issue_rob_entry (mul_rob_entry), .issue_op (mul_op), .full (mul_full)
    );

    rs_station #(.num_entries(rs_pkg::DIV_ENTRIES)) div_rs_i (
        .clk (clk), .rst (rst), .insert (div_insert),
        .ps1 (ps1), .ps2 (ps2), .pd (pd),
        .src1_ready (src1_ready), .src2_ready (src2_ready),
        .rob_entry (rob_entry), .op (op),
        .alu_result_valid (alu_result_valid), .mul_result_valid (mul_result_valid),
        .div_result_valid (div_result_valid), .alu_result_tag (alu_result_tag),
        .mul_result_tag (mul_result_tag), .div_result_tag (div_result_tag),
        .fu_busy (div_fu_busy), .fu_ready (div_fu_ready),
        .issue_ps1 (div_ps1), .issue_ps2 (div_ps2), .issue_pd (div_pd),
        .issue_rob_entry (div_rob_entry), .issue_op (div_op), .full (div_full)
    );

endmodule

`default_nettype wire

/* test/rs_tb_table.svh */
`ifndef RS_TB_TABLE_SVH
`define RS_TB_TABLE_SVH

    // one row per cycle with test name, dispatch, result bus and busy inputs
    // then expected full, fu_ready and alu, mul, div issue fields
    // 3-bit columns are {alu, mul, div}
    function automatic void fill_table();
        // ready at dispatch and issued one cycle later
        add_row("basic", NO_DISP, NO_RES, 3'b000, 3'b000, 3'b000, NO_ISS, NO_ISS, NO_ISS);
        add_row("basic",
                dispatch_to(SEL_ALU, 6'd1, 1'b1, 6'd2, 1'b1, 6'd3, 6'd4, 4'd5),
                NO_RES, 3'b000, 3'b000, 3'b000, NO_ISS, NO_ISS, NO_ISS);
        add_row("basic", NO_DISP, NO_RES, 3'b000, 3'b000, 3'b100,
                issued(6'd1, 6'd2, 6'd3, 6'd4, 4'd5), NO_ISS, NO_ISS);
        add_row("basic", NO_DISP, NO_RES, 3'b000, 3'b000, 3'b000, NO_ISS, NO_ISS, NO_ISS);

        // stored entry waits on ps1 and ignores a tag with valid low
        add_row("wakeup",
                dispatch_to(SEL_ALU, 6'd10, 1'b0, 6'd11, 1'b1, 6'd12, 6'd13, 4'd1),
                NO_RES, 3'b000, 3'b000, 3'b000, NO_ISS, NO_ISS, NO_ISS);
        add_row("wakeup", NO_DISP, result_on(SEL_ALU, 1'b0, 6'd10),
                3'b000, 3'b000, 3'b000, NO_ISS, NO_ISS, NO_ISS);
        add_row("wakeup", NO_DISP, result_on(SEL_MUL, 1'b1, 6'd10),
                3'b000, 3'b000, 3'b000, NO_ISS, NO_ISS, NO_ISS);
        add_row("wakeup", NO_DISP, NO_RES, 3'b000, 3'b000, 3'b100,
                issued(6'd10, 6'd11, 6'd12, 6'd13, 4'd1), NO_ISS, NO_ISS);
        add_row("wakeup", NO_DISP, NO_RES, 3'b000, 3'b000, 3'b000, NO_ISS, NO_ISS, NO_ISS);

        // ps2 broadcast in the dispatch cycle itself
        add_row("early_wakeup",
                dispatch_to(SEL_DIV, 6'd20, 1'b1, 6'd21, 1'b0, 6'd22, 6'd23, 4'd2),
                result_on(SEL_DIV, 1'b1, 6'd21), 3'b000, 3'b000, 3'b000, NO_ISS, NO_ISS, NO_ISS);
        add_row("early_wakeup", NO_DISP, NO_RES, 3'b000, 3'b000, 3'b001,
                NO_ISS, NO_ISS, issued(6'd20, 6'd21, 6'd22, 6'd23, 4'd2));
        add_row("early_wakeup", NO_DISP, NO_RES, 3'b000, 3'b000, 3'b000, NO_ISS, NO_ISS, NO_ISS);

        // station fills behind a busy unit so the third dispatch is dropped
        add_row("backpressure",
                dispatch_to(SEL_MUL, 6'd30, 1'b1, 6'd31, 1'b1, 6'd32, 6'd33, 4'd3),
                NO_RES, 3'b010, 3'b000, 3'b000, NO_ISS, NO_ISS, NO_ISS);
        add_row("backpressure",
                dispatch_to(SEL_MUL, 6'd34, 1'b1, 6'd35, 1'b1, 6'd36, 6'd37, 4'd4),
                NO_RES, 3'b010, 3'b000, 3'b000, NO_ISS, NO_ISS, NO_ISS);
        add_row("backpressure",
                dispatch_to(SEL_MUL, 6'd40, 1'b1, 6'd41, 1'b1, 6'd42, 6'd43, 4'd6),
                NO_RES, 3'b010, 3'b010, 3'b000, NO_ISS, NO_ISS, NO_ISS);
        add_row("backpressure", NO_DISP, NO_RES, 3'b010, 3'b010, 3'b000, NO_ISS, NO_ISS, NO_ISS);
        add_row("backpressure", NO_DISP, NO_RES, 3'b000, 3'b010, 3'b010,
                NO_ISS, issued(6'd30, 6'd31, 6'd32, 6'd33, 4'd3), NO_ISS);
        add_row("backpressure", NO_DISP, NO_RES, 3'b000, 3'b000, 3'b010,
                NO_ISS, issued(6'd34, 6'd35, 6'd36, 6'd37, 4'd4), NO_ISS);
        add_row("backpressure", NO_DISP, NO_RES, 3'b000, 3'b000, 3'b000, NO_ISS, NO_ISS, NO_ISS);

        // one alu broadcast of tag 50 releases all three stations
        add_row("parallel",
                dispatch_to(SEL_ALU, 6'd50, 1'b0, 6'd51, 1'b1, 6'd52, 6'd54, 4'd7),
                NO_RES, 3'b000, 3'b000, 3'b000, NO_ISS, NO_ISS, NO_ISS);
        add_row("parallel",
                dispatch_to(SEL_MUL, 6'd55, 1'b1, 6'd50, 1'b0, 6'd56, 6'd57, 4'd8),
                NO_RES, 3'b000, 3'b000, 3'b000, NO_ISS, NO_ISS, NO_ISS);
        add_row("parallel",
                dispatch_to(SEL_DIV, 6'd50, 1'b0, 6'd58, 1'b1, 6'd59, 6'd60, 4'd9),
                result_on(SEL_ALU, 1'b1, 6'd50), 3'b000, 3'b000, 3'b000, NO_ISS, NO_ISS, NO_ISS);
        add_row("parallel", NO_DISP, NO_RES, 3'b000, 3'b000, 3'b111,
                issued(6'd50, 6'd51, 6'd52, 6'd54, 4'd7),
                issued(6'd55, 6'd50, 6'd56, 6'd57, 4'd8),
                issued(6'd50, 6'd58, 6'd59, 6'd60, 4'd9));

        // code 3 reaches no station
        add_row("unused_select",
                dispatch_to(SEL_NONE, 6'd1, 1'b1, 6'd2, 1'b1, 6'd3, 6'd4, 4'd5),
                NO_RES, 3'b000, 3'b000, 3'b000, NO_ISS, NO_ISS, NO_ISS);
        add_row("unused_select", NO_DISP, NO_RES, 3'b000, 3'b000, 3'b000, NO_ISS, NO_ISS, NO_ISS);
    endfunction

`endif

/* test/rs_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rs_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;

    localparam rs_pkg::rs_sel_t SEL_ALU  = rs_pkg::RS_SEL_ALU;
    localparam rs_pkg::rs_sel_t SEL_MUL  = rs_pkg::RS_SEL_MUL;
    localparam rs_pkg::rs_sel_t SEL_DIV  = rs_pkg::RS_SEL_DIV;
    localparam rs_pkg::rs_sel_t SEL_NONE = 2'd3;  // no station behind this code

    // row columns packed in DUT port order
    typedef logic [32:0] disp_t;  // valid, select, ps1, ps1 ready, ps2, ps2 ready, pd, rob, op
    typedef logic [20:0] res_t;   // alu, mul, div valid and tag
    typedef logic [27:0] iss_t;   // ps1, ps2, pd, rob, op

    typedef struct packed {
        disp_t      disp;
        res_t       res;
        logic [2:0] busy;   // {alu, mul, div}
        logic [2:0] full;
        logic [2:0] ready;
        iss_t       alu;
        iss_t       mul;
        iss_t       div;
    } row_t;

    localparam disp_t NO_DISP = '0;
    localparam res_t  NO_RES  = '0;
    localparam iss_t  NO_ISS  = '0;

    logic clk = 1'b0;
    logic rst;

    logic             dispatch_valid, ps1_ready, ps2_ready;
    rs_pkg::rs_sel_t  rs_select;
    rs_pkg::preg_t    ps1, ps2, pd;
    rs_pkg::rob_idx_t rob_entry;
    rs_pkg::op_t      op;
    logic             alu_full, mul_full, div_full;

    logic             alu_result_valid, mul_result_valid, div_result_valid;
    rs_pkg::preg_t    alu_result_tag, mul_result_tag, div_result_tag;

    logic             alu_fu_busy, mul_fu_busy, div_fu_busy;
    logic             alu_fu_ready, mul_fu_ready, div_fu_ready;
    rs_pkg::preg_t    alu_ps1, alu_ps2, alu_pd;
    rs_pkg::preg_t    mul_ps1, mul_ps2, mul_pd;
    rs_pkg::preg_t    div_ps1, div_ps2, div_pd;
    rs_pkg::rob_idx_t alu_rob_entry, mul_rob_entry, div_rob_entry;
    rs_pkg::op_t      alu_op, mul_op, div_op;

    string row_names[$];
    row_t  rows[$];
    logic  loaded = 1'b0;  // table is filled
    int    passes = 0;
    int    fails = 0;
    int    test_fails = 0;

    rs_top dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic disp_t dispatch_to(input rs_pkg::rs_sel_t sel,
                                          input rs_pkg::preg_t src1, input logic rdy1,
                                          input rs_pkg::preg_t src2, input logic rdy2,
                                          input rs_pkg::preg_t dest,
                                          input rs_pkg::rob_idx_t rob,
                                          input rs_pkg::op_t code);
        return {1'b1, sel, src1, rdy1, src2, rdy2, dest, rob, code};
    endfunction

    // one port broadcasts, the other two stay idle
    function automatic res_t result_on(input rs_pkg::rs_sel_t port, input logic valid,
                                       input rs_pkg::preg_t tag);
        res_t res;
        res = '0;
        case (port)
            SEL_ALU: res[20:14] = {valid, tag};
            SEL_MUL: res[13:7]  = {valid, tag};
            default: res[6:0]   = {valid, tag};
        endcase
        return res;
    endfunction

    function automatic iss_t issued(input rs_pkg::preg_t src1, input rs_pkg::preg_t src2,
                                    input rs_pkg::preg_t dest, input rs_pkg::rob_idx_t rob,
                                    input rs_pkg::op_t code);
        return {src1, src2, dest, rob, code};
    endfunction

    function automatic void add_row(input string name, input disp_t disp, input res_t res,
                                    input logic [2:0] busy, input logic [2:0] full,
                                    input logic [2:0] ready, input iss_t alu,
                                    input iss_t mul, input iss_t div);
        row_names.push_back(name);
        rows.push_back({disp, res, busy, full, ready, alu, mul, div});
    endfunction

    `include "rs_tb_table.svh"

    task automatic apply_inputs(input row_t row);
        {dispatch_valid, rs_select, ps1, ps1_ready, ps2, ps2_ready, pd, rob_entry, op}
            <= row.disp;
        {alu_result_valid, alu_result_tag, mul_result_valid, mul_result_tag,
         div_result_valid, div_result_tag} <= row.res;
        {alu_fu_busy, mul_fu_busy, div_fu_busy} <= row.busy;
    endtask

    task automatic compare(input string test, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("error: %s %s expected %h actual %h", test, what, expected, actual);
            fails++;
            test_fails++;
        end
        else
        begin
            passes++;
        end
    endtask

    task automatic check_row(input string name, input row_t row);
        compare(name, "full", 32'(row.full), 32'({alu_full, mul_full, div_full}));
        compare(name, "fu_ready", 32'(row.ready),
                32'({alu_fu_ready, mul_fu_ready, div_fu_ready}));
        compare(name, "alu issue", 32'(row.alu),
                32'({alu_ps1, alu_ps2, alu_pd, alu_rob_entry, alu_op}));
        compare(name, "mul issue", 32'(row.mul),
                32'({mul_ps1, mul_ps2, mul_pd, mul_rob_entry, mul_op}));
        compare(name, "div issue", 32'(row.div),
                32'({div_ps1, div_ps2, div_pd, div_rob_entry, div_op}));
    endtask

    initial
    begin
        int last;
        rst <= 1'b1;
        apply_inputs('0);
        fill_table();
        loaded = 1'b1;
        last = rows.size() - 1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i <= last; i++)
        begin
            @(posedge clk);
            apply_inputs(rows[i]);
            @(negedge clk);  // outputs settled mid cycle
            check_row(row_names[i], rows[i]);
            if (i == last || row_names[i + 1] != row_names[i])
            begin
                $display("test %s finished, %0d mismatches", row_names[i], test_fails);
                test_fails = 0;
            end
        end
        $display("summary: %0d checks matched, %0d mismatched", passes, fails);
        if (fails == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    // whole table plus reset and some slack
    initial
    begin
        wait (loaded);
        #((rows.size() + RESET_CYCLES + 10) * CLK_PERIOD);
        $display("timeout: the run did not reach the end of the table");
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+test
src/rs_pkg.sv
src/rs_pick.sv
src/rs_station.sv
src/rs_dispatch_route.sv
src/rs_top.sv
test/rs_tb.sv

/* Makefile */
SRCS := $(wildcard src/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: run clean

run: build/Vrs_tb
	@out=$$(./build/Vrs_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

build/Vrs_tb: all.f $(SRCS)
	verilator --binary --timing --timescale 1ns/100ps -f all.f \
		--top-module rs_tb -Mdir build -o Vrs_tb

clean:
	rm -rf build
